// ==== common/cpu_types_pkg.sv ====
/* shared types for the two-cpu memory subsystem; widths fixed at 32-bit words
   ram sees address bits 11:2 only, so upper address bits alias */
package cpu_types_pkg;

  // number of caches on the bus
  localparam int CPUS = 2;

  // busy cycles before each ram access completes
  localparam int RAM_LAT = 2;

  // word index width and depth of the ram
  localparam int RAM_ADDR_BITS = 10;
  localparam int RAM_WORDS = 1 << RAM_ADDR_BITS;

  // latency counter must reach RAM_LAT
  localparam int RAM_CNT_BITS = $clog2(RAM_LAT + 1);

  // data word or byte address
  typedef logic [31:0] word_t;

  // word index into ram
  typedef logic [RAM_ADDR_BITS-1:0] ram_addr_t;

  // selects one of the caches
  typedef logic [$clog2(CPUS)-1:0] cpu_idx_t;

  // ram latency count
  typedef logic [RAM_CNT_BITS-1:0] ram_cnt_t;

  // FREE: idle, BUSY: latency running, ACCESS: word done this cycle
  typedef enum logic [1:0]
  {
    FREE,
    BUSY,
    ACCESS
  } ramstate_t;

endpackage

// ==== design/memory_control/memory_control.sv ====
/* MSI snoop controller and ram arbiter for exactly two caches; a block is two words
   sent one after another on the same ports, each request held until its wait falls */
`timescale 1ns/1ps

module memory_control
  import cpu_types_pkg::*;
(
  input  logic            CLK,
  input  logic            nRST,
  // cache requests
  input  logic [CPUS-1:0] iren,
  input  logic [CPUS-1:0] dren,
  input  logic [CPUS-1:0] dwen,
  input  logic [CPUS-1:0] cctrans,
  input  logic [CPUS-1:0] ccwrite,
  input  word_t           iaddr [CPUS],
  input  word_t           daddr [CPUS],
  input  word_t           dstore [CPUS],
  // cache responses
  output logic [CPUS-1:0] iwait,
  output logic [CPUS-1:0] dwait,
  output logic [CPUS-1:0] ccwait,
  output logic [CPUS-1:0] ccinv,
  output word_t           iload [CPUS],
  output word_t           dload [CPUS],
  output word_t           ccsnoopaddr [CPUS],
  // ram side
  input  word_t           ram_load,
  input  ramstate_t       ram_state,
  output logic            ram_ren,
  output logic            ram_wen,
  output word_t           ram_addr,
  output word_t           ram_store
);

  typedef enum logic [3:0]
  {
    IDLE,
    INSTRUCTION,
    STORE_1,
    STORE_2,
    LOAD_1,
    LOAD_2,
    ARBITRATE,
    SNOOP,
    CACHE_1,
    CACHE_2
  } state_t;

  state_t   state;
  state_t   next_state;
  // least recently served cpu, wins a tie
  cpu_idx_t lru;
  cpu_idx_t next_lru;
  // owner of the current transaction and the other cache
  cpu_idx_t snooper;
  cpu_idx_t next_snooper;
  cpu_idx_t snooped;
  cpu_idx_t next_snooped;
  // candidates picked by request type
  cpu_idx_t wb_cpu;
  cpu_idx_t if_cpu;
  cpu_idx_t arb_cpu;
  logic     ram_done;

  // requested cpu, lru one first
  function automatic cpu_idx_t lru_pick(input logic [CPUS-1:0] req, input cpu_idx_t pref);
    return req[pref] ? pref : ~pref;
  endfunction

  assign wb_cpu   = lru_pick(dwen, lru);
  assign if_cpu   = lru_pick(iren, lru);
  // a read beats a bare upgrade
  assign arb_cpu  = (|dren) ? lru_pick(dren, lru) : lru_pick(cctrans, lru);
  assign ram_done = (ram_state == ACCESS);

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      state   <= IDLE;
      lru     <= '0;
      snooper <= '0;
      snooped <= '1;
    end
    else
    begin
      state   <= next_state;
      lru     <= next_lru;
      snooper <= next_snooper;
      snooped <= next_snooped;
    end
  end

  // next state and owner latch
  always_comb
  begin
    next_state   = state;
    next_snooper = snooper;
    next_snooped = snooped;
    case (state)
      IDLE:
      begin
        // write-back first, then coherence or read, then fetch
        if (|dwen)
        begin
          next_state   = STORE_1;
          next_snooper = wb_cpu;
          next_snooped = ~wb_cpu;
        end
        else if ((|cctrans) || (|dren))
        begin
          next_state = ARBITRATE;
        end
        else if (|iren)
        begin
          next_state   = INSTRUCTION;
          next_snooper = if_cpu;
          next_snooped = ~if_cpu;
        end
      end
      INSTRUCTION:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      STORE_1:
      begin
        if (ram_done)
        begin
          next_state = STORE_2;
        end
      end
      STORE_2:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      ARBITRATE:
      begin
        // upgrade alone finishes here
        if (|dren)
        begin
          next_state   = SNOOP;
          next_snooper = arb_cpu;
          next_snooped = ~arb_cpu;
        end
        else
        begin
          next_state = IDLE;
        end
      end
      SNOOP:
      begin
        // other cache transitioning means it holds the block
        next_state = cctrans[snooped] ? CACHE_1 : LOAD_1;
      end
      CACHE_1:
      begin
        if (ram_done)
        begin
          next_state = CACHE_2;
        end
      end
      CACHE_2:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      LOAD_1:
      begin
        if (ram_done)
        begin
          next_state = LOAD_2;
        end
      end
      LOAD_2:
      begin
        if (ram_done)
        begin
          next_state = IDLE;
        end
      end
      default:
      begin
        next_state = IDLE;
      end
    endcase
  end

  // bus outputs, waits fall at ACCESS
  always_comb
  begin
    iwait       = '1;
    dwait       = '1;
    ccwait      = '0;
    ccinv       = '0;
    iload       = '{default: '0};
    dload       = '{default: '0};
    ccsnoopaddr = '{default: '0};
    ram_ren     = 1'b0;
    ram_wen     = 1'b0;
    ram_addr    = '0;
    ram_store   = '0;
    next_lru    = lru;
    case (state)
      INSTRUCTION:
      begin
        ram_ren         = 1'b1;
        ram_addr        = iaddr[snooper];
        iload[snooper]  = ram_load;
        if (ram_done)
        begin
          iwait[snooper] = 1'b0;
          next_lru       = snooped;
        end
      end
      STORE_1, STORE_2:
      begin
        ram_wen         = 1'b1;
        ram_addr        = daddr[snooper];
        ram_store       = dstore[snooper];
        // hold the other cache off during write-back
        ccwait[snooped] = 1'b1;
        if (ram_done)
        begin
          dwait[snooper] = 1'b0;
          if (state == STORE_2)
          begin
            next_lru = snooped;
          end
        end
      end
      ARBITRATE:
      begin
        if ((|dren) || (|cctrans))
        begin
          ccwait[~arb_cpu] = 1'b1;
        end
        // S to M hit with no read, invalidate the other copy
        if (!(|dren) && (|cctrans))
        begin
          ccinv[~arb_cpu]       = 1'b1;
          ccsnoopaddr[~arb_cpu] = daddr[arb_cpu];
          dwait[arb_cpu]        = 1'b0;
          next_lru              = ~arb_cpu;
        end
      end
      SNOOP:
      begin
        ccsnoopaddr[snooped] = daddr[snooper];
      end
      CACHE_1, CACHE_2:
      begin
        ccsnoopaddr[snooped] = daddr[snooper];
        // peer data to requester
        dload[snooper]       = dstore[snooped];
        // requester going to M drops the peer copy
        ccinv[snooped]       = ccwrite[snooper];
        // same word also written back to ram
        ram_wen              = 1'b1;
        ram_addr             = daddr[snooper];
        ram_store            = dstore[snooped];
        if (ram_done)
        begin
          dwait[snooper] = 1'b0;
          dwait[snooped] = 1'b0;
          if (state == CACHE_2)
          begin
            next_lru = snooped;
          end
        end
      end
      LOAD_1, LOAD_2:
      begin
        ram_ren        = 1'b1;
        ram_addr       = daddr[snooper];
        dload[snooper] = ram_load;
        if (ram_done)
        begin
          dwait[snooper] = 1'b0;
          if (state == LOAD_2)
          begin
            next_lru = snooped;
          end
        end
      end
      default:
      begin
      end
    endcase
  end

  // one ram operation at a time
  a_ram_one_op: assert property (@(posedge CLK) disable iff (!nRST)
    !(ram_ren && ram_wen));

  // only one cache is invalidated
  a_single_inv: assert property (@(posedge CLK) disable iff (!nRST)
    !(&ccinv));

  // snoop decision takes exactly one cycle
  a_snoop_one_cycle: assert property (@(posedge CLK) disable iff (!nRST)
    (state == SNOOP) |=> (state inside {CACHE_1, LOAD_1}));

endmodule

// ==== design/ram.sv ====
/* word ram, RAM_LAT busy cycles then one ACCESS cycle; address bits 11:2 only
   changing address or enable mid-access restarts the count, no preload */
`timescale 1ns/1ps

module ram
  import cpu_types_pkg::*;
(
  input  logic      CLK,
  input  logic      nRST,
  input  logic      ram_ren,
  input  logic      ram_wen,
  input  word_t     ram_addr,
  input  word_t     ram_store,
  output word_t     ram_load,
  output ramstate_t ram_state
);

  word_t     mem [RAM_WORDS];
  ram_addr_t word_idx;
  // previous cycle request
  word_t     last_addr;
  logic      last_ren;
  logic      last_wen;
  // busy cycles seen so far
  ram_cnt_t  lat_cnt;
  logic      req;
  logic      same_req;

  // byte address to word index
  assign word_idx = ram_addr[RAM_ADDR_BITS+1:2];
  assign req      = ram_ren || ram_wen;
  assign same_req = (ram_addr == last_addr) && (ram_ren == last_ren) && (ram_wen == last_wen);

  always_comb
  begin
    if (!req)
    begin
      ram_state = FREE;
    end
    else if (same_req && (lat_cnt == ram_cnt_t'(RAM_LAT)))
    begin
      ram_state = ACCESS;
    end
    else
    begin
      ram_state = BUSY;
    end
  end

  always_ff @(posedge CLK, negedge nRST)
  begin
    if (!nRST)
    begin
      last_addr <= '0;
      last_ren  <= 1'b0;
      last_wen  <= 1'b0;
      lat_cnt   <= '0;
    end
    else
    begin
      last_addr <= ram_addr;
      last_ren  <= ram_ren;
      last_wen  <= ram_wen;
      if (!req)
      begin
        lat_cnt <= '0;
      end
      else if (!same_req)
      begin
        // new request, this cycle was the first busy one
        lat_cnt <= ram_cnt_t'(1);
      end
      else if (ram_state == ACCESS)
      begin
        // still held, start over
        lat_cnt <= '0;
      end
      else
      begin
        lat_cnt <= lat_cnt + 1'b1;
      end
    end
  end

  // write lands at the ACCESS edge
  always_ff @(posedge CLK)
  begin
    if ((ram_state == ACCESS) && ram_wen)
    begin
      mem[word_idx] <= ram_store;
    end
  end

  assign ram_load = mem[word_idx];

  // access only while requested, always after a busy cycle
  a_access_needs_req: assert property (@(posedge CLK) disable iff (!nRST)
    (ram_state == ACCESS) |-> (ram_ren || ram_wen) && ($past(ram_state) == BUSY));

endmodule

// ==== design/memory_system.sv ====
/* two-cache coherent memory top; controller and ram joined by the ram bus
   cache-side ports pass straight through, one entry per cpu */
`timescale 1ns/1ps

module memory_system
  import cpu_types_pkg::*;
(
  input  logic            CLK,
  input  logic            nRST,
  // cache requests
  input  logic [CPUS-1:0] iren,
  input  logic [CPUS-1:0] dren,
  input  logic [CPUS-1:0] dwen,
  input  logic [CPUS-1:0] cctrans,
  input  logic [CPUS-1:0] ccwrite,
  input  word_t           iaddr [CPUS],
  input  word_t           daddr [CPUS],
  input  word_t           dstore [CPUS],
  // cache responses
  output logic [CPUS-1:0] iwait,
  output logic [CPUS-1:0] dwait,
  output logic [CPUS-1:0] ccwait,
  output logic [CPUS-1:0] ccinv,
  output word_t           iload [CPUS],
  output word_t           dload [CPUS],
  output word_t           ccsnoopaddr [CPUS]
);

  // ram bus
  logic      ram_ren;
  logic      ram_wen;
  word_t     ram_addr;
  word_t     ram_store;
  word_t     ram_load;
  ramstate_t ram_state;

  // cache and ram port names match one to one
  memory_control u_memory_control (.*);

  ram u_ram
  (
    .CLK       (CLK),
    .nRST      (nRST),
    .ram_ren   (ram_ren),
    .ram_wen   (ram_wen),
    .ram_addr  (ram_addr),
    .ram_store (ram_store),
    .ram_load  (ram_load),
    .ram_state (ram_state)
  );

endmodule

// ==== verification/memory_system_tb.sv ====
/* testbench plays both caches and both cpus; only words written earlier are read back
   ram has no preload, so untouched words read as X */
`timescale 1ns/1ps

module memory_system_tb
  import cpu_types_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  // word accesses of the whole run, each upgrade counted as one
  localparam int N_ACCESS = 39;
  localparam int WATCHDOG_CYCLES = N_ACCESS * (RAM_LAT + 4) + 200;

  logic            CLK;
  logic            nRST;
  logic [CPUS-1:0] iren;
  logic [CPUS-1:0] dren;
  logic [CPUS-1:0] dwen;
  logic [CPUS-1:0] cctrans;
  logic [CPUS-1:0] ccwrite;
  word_t           iaddr [CPUS];
  word_t           daddr [CPUS];
  word_t           dstore [CPUS];
  logic [CPUS-1:0] iwait;
  logic [CPUS-1:0] dwait;
  logic [CPUS-1:0] ccwait;
  logic [CPUS-1:0] ccinv;
  word_t           iload [CPUS];
  word_t           dload [CPUS];
  word_t           ccsnoopaddr [CPUS];

  // model of ram contents, written on every completed write word
  word_t ref_mem [RAM_WORDS];
  word_t lcg_state;
  int    checks;
  int    errors;
  // last cpu whose fetch was served, and whether the other one was waiting then
  int    last_if;
  logic  last_pend;

  memory_system u_dut (.*);

  initial
  begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  function automatic word_t lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // upper address bits alias, bits 1:0 pick a byte
  function automatic ram_addr_t word_index(input word_t addr);
    return addr[RAM_ADDR_BITS+1:2];
  endfunction

  function automatic word_t ref_load(input word_t addr);
    return ref_mem[word_index(addr)];
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("[FAIL] %0t: %s", $time, msg);
  endtask

  task automatic wait_fetch_served(input int c);
    @(negedge CLK);
    while (iwait[c])
      @(negedge CLK);
  endtask

  task automatic wait_data_served(input int c);
    @(negedge CLK);
    while (dwait[c])
      @(negedge CLK);
  endtask

  // n words in a row, iren stays high between words
  task automatic fetch(input int c, input word_t addr, input int n);
    int i;
    @(posedge CLK);
    iren[c]  <= 1'b1;
    iaddr[c] <= addr;
    for (i = 0; i < n; i++)
    begin
      wait_fetch_served(c);
      @(posedge CLK);
      iaddr[c] <= addr + word_t'(4 * (i + 1));
    end
    iren[c] <= 1'b0;
  endtask

  task automatic write_block(input int c, input word_t addr, input word_t w0, input word_t w1);
    @(posedge CLK);
    dwen[c]   <= 1'b1;
    daddr[c]  <= addr;
    dstore[c] <= w0;
    wait_data_served(c);
    @(posedge CLK);
    daddr[c]  <= addr + 4;
    dstore[c] <= w1;
    wait_data_served(c);
    @(posedge CLK);
    dwen[c] <= 1'b0;
  endtask

  // read miss, ccw set when the block goes to M
  task automatic read_block(input int c, input word_t addr, input logic ccw);
    @(posedge CLK);
    dren[c]    <= 1'b1;
    cctrans[c] <= 1'b1;
    ccwrite[c] <= ccw;
    daddr[c]   <= addr;
    wait_data_served(c);
    @(posedge CLK);
    daddr[c] <= addr + 4;
    wait_data_served(c);
    @(posedge CLK);
    dren[c]    <= 1'b0;
    cctrans[c] <= 1'b0;
    ccwrite[c] <= 1'b0;
  endtask

  // snooped cache holding the block, hands both words over
  task automatic supply_block(input int c, input word_t w0, input word_t w1);
    @(posedge CLK);
    cctrans[c] <= 1'b1;
    ccwrite[c] <= 1'b0;
    dstore[c]  <= w0;
    wait_data_served(c);
    @(posedge CLK);
    dstore[c] <= w1;
    wait_data_served(c);
    @(posedge CLK);
    cctrans[c] <= 1'b0;
  endtask

  // S to M with no read, done in ARBITRATE right after IDLE
  task automatic upgrade(input int c, input word_t addr);
    int cycles;
    @(posedge CLK);
    cctrans[c] <= 1'b1;
    ccwrite[c] <= 1'b1;
    daddr[c]   <= addr;
    @(negedge CLK);
    cycles = 1;
    while (dwait[c])
    begin
      @(negedge CLK);
      cycles++;
    end
    checks++;
    if (cycles > 2)
      report_mismatch($sformatf("upgrade on cpu %0d took %0d cycles", c, cycles));
    @(posedge CLK);
    cctrans[c] <= 1'b0;
    ccwrite[c] <= 1'b0;
  endtask

  // compare every completed word against the model
  always @(negedge CLK)
  begin : compare_words
    int c;
    int p;
    if (nRST)
    begin
      for (c = 0; c < CPUS; c++)
      begin
        p = 1 - c;
        if (iren[c] && !iwait[c])
        begin
          checks++;
          if (iload[c] !== ref_load(iaddr[c]))
            report_mismatch($sformatf("cpu %0d iload %h at %h, expected %h",
              c, iload[c], iaddr[c], ref_load(iaddr[c])));
          // the same cpu twice while the other waited
          if ((last_if == c) && last_pend && iren[p])
            report_mismatch($sformatf("cpu %0d fetch served twice, cpu %0d waiting", c, p));
          last_if   = c;
          last_pend = iren[p];
        end
        if (dren[c] && !dwait[c])
        begin
          checks++;
          if (cctrans[p])
          begin
            // word comes from the peer cache
            if (dload[c] !== dstore[p])
              report_mismatch($sformatf("cpu %0d dload %h, peer sent %h", c, dload[c], dstore[p]));
            if (ccsnoopaddr[p] !== daddr[c])
              report_mismatch($sformatf("snoop addr %h, expected %h", ccsnoopaddr[p], daddr[c]));
            if (ccinv[p] !== ccwrite[c])
              report_mismatch($sformatf("ccinv on cpu %0d is %b", p, ccinv[p]));
            ref_mem[word_index(daddr[c])] = dstore[p];
          end
          else
          begin
            if (dload[c] !== ref_load(daddr[c]))
              report_mismatch($sformatf("cpu %0d dload %h at %h, expected %h",
                c, dload[c], daddr[c], ref_load(daddr[c])));
            if (ccinv[p] !== 1'b0)
              report_mismatch($sformatf("ccinv on cpu %0d during a ram read", p));
          end
        end
        if (dwen[c] && !dwait[c])
        begin
          checks++;
          if (ccwait[p] !== 1'b1)
            report_mismatch($sformatf("cpu %0d not held off during write-back", p));
          ref_mem[word_index(daddr[c])] = dstore[c];
        end
        if (cctrans[c] && ccwrite[c] && !dren[c] && !dwait[c])
        begin
          checks++;
          if (ccinv[p] !== 1'b1)
            report_mismatch($sformatf("no ccinv on cpu %0d for upgrade", p));
          if (ccsnoopaddr[p] !== daddr[c])
            report_mismatch($sformatf("upgrade snoop addr %h, expected %h",
              ccsnoopaddr[p], daddr[c]));
          // snooped cache held off while arbitrating
          if (ccwait[p] !== 1'b1)
            report_mismatch($sformatf("cpu %0d not held off during upgrade", p));
        end
      end
    end
  end

  initial
  begin : stimulus
    time wb_done;
    time other_done;
    nRST      = 1'b0;
    iren      = '0;
    dren      = '0;
    dwen      = '0;
    cctrans   = '0;
    ccwrite   = '0;
    iaddr     = '{default: '0};
    daddr     = '{default: '0};
    dstore    = '{default: '0};
    lcg_state = 32'd94025;
    checks    = 0;
    errors    = 0;
    last_if   = -1;
    last_pend = 1'b0;
    repeat (5) @(posedge CLK);
    nRST <= 1'b1;

    // idle bus right after reset
    @(negedge CLK);
    checks++;
    if ((iwait !== '1) || (dwait !== '1))
      report_mismatch($sformatf("waits after reset i=%b d=%b", iwait, dwait));
    if ((ccinv !== '0) || (ccwait !== '0))
      report_mismatch($sformatf("cc after reset inv=%b wait=%b", ccinv, ccwait));

    // block written by cpu 0, fetched by both
    write_block(0, 32'h100, lcg_next(), lcg_next());
    fetch(0, 32'h100, 2);
    fetch(1, 32'h100, 2);

    // both fetch four words at once
    write_block(1, 32'h200, lcg_next(), lcg_next());
    write_block(0, 32'h208, lcg_next(), lcg_next());
    fork
      fetch(0, 32'h200, 4);
      fetch(1, 32'h200, 4);
    join

    // write-back first against a fetch, then against a read
    fork
      begin
        write_block(1, 32'h300, lcg_next(), lcg_next());
        wb_done = $time;
      end
      begin
        fetch(0, 32'h100, 1);
        other_done = $time;
      end
    join
    checks++;
    if (other_done <= wb_done)
      report_mismatch("fetch served ahead of a simultaneous write-back");
    fork
      begin
        write_block(1, 32'h308, lcg_next(), lcg_next());
        wb_done = $time;
      end
      begin
        read_block(0, 32'h100, 1'b0);
        other_done = $time;
      end
    join
    checks++;
    if (other_done <= wb_done)
      report_mismatch("read served ahead of a simultaneous write-back");

    // read misses with no snoop hit
    read_block(1, 32'h300, 1'b0);
    read_block(0, 32'h208, 1'b1);

    // cache to cache, once toward M and once toward S
    fork
      read_block(0, 32'h400, 1'b1);
      supply_block(1, lcg_next(), lcg_next());
    join
    fork
      read_block(1, 32'h500, 1'b0);
      supply_block(0, lcg_next(), lcg_next());
    join
    // transferred words must also be in ram
    read_block(1, 32'h400, 1'b0);
    read_block(0, 32'h500, 1'b0);

    upgrade(0, 32'h400);
    upgrade(1, 32'h208);

    repeat (4) @(posedge CLK);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
    begin
      $display(">>> PASS");
    end
    else
    begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // hang guard sized from the number of accesses
  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK);
    $display("timeout: no result after %0d cycles, the DUT seems to hang", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

endmodule

// ==== compile.f ====
common/cpu_types_pkg.sv
design/memory_control/memory_control.sv
design/ram.sv
design/memory_system.sv
verification/memory_system_tb.sv

// ==== Bender.yml ====
package:
  name: memory_system

sources:
  - common/cpu_types_pkg.sv
  - design/memory_control/memory_control.sv
  - design/ram.sv
  - design/memory_system.sv
  - target: test
    files:
      - verification/memory_system_tb.sv
